// ==== list.f ====
+incdir+include
design/snes_cart_pkg.sv
design/cart_type_decode.sv
design/lohi_rom_map.sv
design/msu_regs.sv
design/cart_data_mux.sv
design/snes_cart_bus.sv
verification/tb_snes_cart_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and reports the result by exit status.
set -u
cd "$(dirname "$0")" || exit 1

top=tb_snes_cart_bus
log=sim.log

verilator --binary --timing -f list.f --top-module "$top" -o "$top" --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Test failures found" "$log"; then
	echo "Simulation reported failures, see $log"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
echo "Simulation finished cleanly"
exit 0

// ==== include/cart_model.svh ====
`ifndef CART_MODEL_SVH
`define CART_MODEL_SVH

// MSU register state as the DUT should hold it after each edge.
logic [15:0] model_track_num;
cpu_data_t   model_volume;
logic        model_playing;
logic        model_repeat;

function automatic void model_decode(
	input  cart_type_u  t,
	output map_active_t act,
	output logic        hirom,
	output logic        ss_avail,
	output logic        turbo_allow,
	output logic        gsu_active
);
	act = '0;
	if (t.coproc.chip_id == chip_id_cx4) act[chip_cx4] = 1'b1;
	if (t.coproc.chip_id == chip_id_sdd1) act[chip_sdd1] = 1'b1;
	if (t.coproc.chip_id == chip_id_gsu) act[chip_gsu] = 1'b1;
	if (t.coproc.chip_id == chip_id_sa1) act[chip_sa1] = 1'b1;
	if (t.coproc.chip_id == chip_id_spc7110) act[chip_spc7110] = 1'b1;
	if (t.coproc.chip_id == chip_id_bsx) act[chip_bsx] = 1'b1;
	if (t.coproc.chip_id == chip_id_sufami) act[chip_sufami] = 1'b1;
	hirom = t.coproc.map_mode[map_mode_hirom];
	ss_avail = (t.coproc.chip_id == chip_id_none) || act[chip_sa1]
		|| (t.dspn.tag == dspn_tag);
	turbo_allow = !(act[chip_sa1] || act[chip_sdd1]);
	gsu_active = act[chip_gsu];
endfunction

// Expected registered outputs one cycle after the bus values given here.
function automatic void model_map(
	input  cpu_addr_t   ca,
	input  logic        romsel_n,
	input  logic        ramsel_n,
	input  logic        hirom,
	input  rom_addr_t   rom_mask,
	input  bsram_addr_t ram_mask,
	output rom_addr_t   rom_addr,
	output logic        rom_ce_n,
	output bsram_addr_t bsram_addr,
	output logic        bsram_ce_n
);
	int   bank;
	int   ofs;
	logic ram_hit;
	logic rom_hit;
	bank = int'(ca[23:16]);
	ofs = int'(ca[15:0]);
	if (hirom) begin
		ram_hit = ((bank >= 'h20 && bank <= 'h3f) || (bank >= 'ha0 && bank <= 'hbf))
			&& ofs >= 'h6000 && ofs <= 'h7fff;
		rom_hit = !romsel_n || (bank >= 'h40 && bank <= 'h7d) || bank >= 'hc0;
		rom_addr = rom_addr_t'(((bank << 16) | ofs) & 'h3fffff) & rom_mask;
		bsram_addr = bsram_addr_t'(((bank & 'h1f) << 13) | (ofs & 'h1fff)) & ram_mask;
	end else begin
		ram_hit = bank >= 'h70 && bank <= 'h7d && ofs < 'h8000;
		rom_hit = !romsel_n;
		rom_addr = rom_addr_t'(((bank & 'h7f) << 15) | (ofs & 'h7fff)) & rom_mask;
		bsram_addr = bsram_addr_t'(((bank & 'hf) << 15) | (ofs & 'h7fff)) & ram_mask;
	end
	ram_hit = ram_hit && ramsel_n;
	rom_hit = rom_hit && ramsel_n && !ram_hit;
	rom_ce_n = !rom_hit;
	bsram_ce_n = !ram_hit;
endfunction

function automatic void model_msu_reset();
	model_track_num = '0;
	model_volume = '0;
	model_playing = 1'b0;
	model_repeat = 1'b0;
endfunction

// The window is eight bytes from the base in banks 00-3F and 80-BF.
function automatic logic model_msu_hit(input logic [15:0] base, input logic enable,
	input cpu_addr_t ca);
	int bank;
	int ofs;
	bank = int'(ca[23:16]);
	ofs = int'(ca[15:0]);
	return enable && (bank <= 'h3f || (bank >= 'h80 && bank <= 'hbf))
		&& ofs >= int'(base) && ofs < int'(base) + 8;
endfunction

// One clock edge of the MSU registers; returns the request expected on the next cycle.
function automatic logic model_msu_step(
	input logic [15:0] base,
	input logic        enable,
	input cpu_addr_t   ca,
	input logic        cpuwr_n,
	input logic        sysclkf_ce,
	input cpu_data_t   d,
	input logic        stop
);
	logic wr;
	wr = model_msu_hit(base, enable, ca) && !cpuwr_n && sysclkf_ce;
	if (wr && ca[2:0] == msu_reg_track_lo) model_track_num[7:0] = d;
	if (wr && ca[2:0] == msu_reg_track_hi) model_track_num[15:8] = d;
	if (wr && ca[2:0] == msu_reg_volume) model_volume = d;
	if (wr && ca[2:0] == msu_reg_control) begin
		model_playing = d[0];
		model_repeat = d[1];
	end else if (stop) begin
		model_playing = 1'b0;
	end
	return wr && (ca[2:0] == msu_reg_track_hi);
endfunction

function automatic cpu_data_t model_msu_read(input cpu_addr_t ca, input logic mounting,
	input logic missing);
	logic [2:0] ofs;
	cpu_data_t  st;
	ofs = ca[2:0];
	st = 8'h00;
	st[6] = mounting;
	st[5] = model_repeat;
	st[4] = model_playing;
	st[3] = missing;
	if (ofs == msu_reg_status) return st;
	if (ofs == msu_reg_data) return 8'h00;
	return msu_id_bytes[ofs - 3'd2];
endfunction

`endif

// ==== verification/tb_snes_cart_bus.sv ====
`timescale 1ns/1ns

module tb_snes_cart_bus;

	import snes_cart_pkg::*;

	`include "cart_model.svh"

	localparam logic [15:0] msu_base = 16'h2000;
	localparam int n_decode = 300;
	localparam int n_map = 2000;
	localparam int n_msu = 1200;
	localparam int total_cycles = 4 + n_decode + n_map + n_msu;
	localparam int timeout_ns = total_cycles * 10 * 2;

	logic        mclk;
	logic        rst_n;
	cart_type_u  rom_type;
	rom_addr_t   rom_mask;
	bsram_addr_t ram_mask;
	cpu_addr_t   ca;
	logic        cpurd_n;
	logic        cpuwr_n;
	logic        romsel_n;
	logic        ramsel_n;
	cpu_data_t   cpu_do;
	logic        sysclkf_ce;
	cpu_data_t   cpu_di;
	rom_addr_t   rom_addr;
	rom_word_t   rom_q;
	logic        rom_ce_n;
	logic        rom_oe_n;
	logic        rom_word;
	bsram_addr_t bsram_addr;
	cpu_data_t   bsram_d;
	cpu_data_t   bsram_q;
	logic        bsram_ce_n;
	logic        bsram_oe_n;
	logic        bsram_we_n;
	map_active_t map_active;
	logic        ss_avail;
	logic        turbo_allow;
	logic        gsu_active;
	logic        msu_enable;
	logic [15:0] msu_track_num;
	logic        msu_track_request;
	logic        msu_track_mounting;
	logic        msu_track_missing;
	cpu_data_t   msu_volume;
	logic        msu_audio_stop;
	logic        msu_audio_repeat;
	logic        msu_audio_playing;

	// Expected values for the registered outputs after the next rising edge.
	rom_addr_t   exp_rom_addr;
	bsram_addr_t exp_bsram_addr;
	logic        exp_rom_ce_n;
	logic        exp_bsram_ce_n;
	logic        exp_rd_n;
	logic        exp_wr_n;
	cpu_data_t   exp_do;
	logic        exp_req;
	logic        have_prev;
	int          errors;

	snes_cart_bus #(
		.msu_base (msu_base)
	) dut0 (
		.mclk               (mclk),
		.rst_n              (rst_n),
		.rom_type           (rom_type),
		.rom_mask           (rom_mask),
		.ram_mask           (ram_mask),
		.ca                 (ca),
		.cpurd_n            (cpurd_n),
		.cpuwr_n            (cpuwr_n),
		.romsel_n           (romsel_n),
		.ramsel_n           (ramsel_n),
		.cpu_do             (cpu_do),
		.sysclkf_ce         (sysclkf_ce),
		.cpu_di             (cpu_di),
		.rom_addr           (rom_addr),
		.rom_q              (rom_q),
		.rom_ce_n           (rom_ce_n),
		.rom_oe_n           (rom_oe_n),
		.rom_word           (rom_word),
		.bsram_addr         (bsram_addr),
		.bsram_d            (bsram_d),
		.bsram_q            (bsram_q),
		.bsram_ce_n         (bsram_ce_n),
		.bsram_oe_n         (bsram_oe_n),
		.bsram_we_n         (bsram_we_n),
		.map_active         (map_active),
		.ss_avail           (ss_avail),
		.turbo_allow        (turbo_allow),
		.gsu_active         (gsu_active),
		.msu_enable         (msu_enable),
		.msu_track_num      (msu_track_num),
		.msu_track_request  (msu_track_request),
		.msu_track_mounting (msu_track_mounting),
		.msu_track_missing  (msu_track_missing),
		.msu_volume         (msu_volume),
		.msu_audio_stop     (msu_audio_stop),
		.msu_audio_repeat   (msu_audio_repeat),
		.msu_audio_playing  (msu_audio_playing)
	);

	initial begin
		mclk = 1'b0;
		forever #5 mclk = ~mclk;
	end

	initial begin
		#(timeout_ns);
		$display("Watchdog expired before the test sequence completed.");
		$display("Test failures found");
		$fatal(1, "Simulation stopped by the watchdog.");
	end

	task automatic stop_on_error();
		errors = errors + 1;
		$display("Test failures found");
		$fatal(1, "Stopping at the first mismatch.");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_byte(input string name, input cpu_data_t exp, input cpu_data_t act);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%02h, got 0x%02h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%04h, got 0x%04h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_addr(input string name, input rom_addr_t exp, input rom_addr_t act);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%06h, got 0x%06h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_ram_addr(input string name, input bsram_addr_t exp,
		input bsram_addr_t act);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%05h, got 0x%05h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_active(input string name, input map_active_t exp,
		input map_active_t act);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%02h, got 0x%02h", name, exp, act);
			stop_on_error();
		end
	endtask

	// Each bus cycle checks what the last edge produced, drives new inputs, checks the
	// combinational outputs and works out what the next edge must produce.
	task automatic bus_cycle(input logic new_type, input logic msu_focus);
		logic [31:0] r;
		map_active_t exp_act;
		logic        exp_hirom;
		logic        exp_ss;
		logic        exp_turbo;
		logic        exp_gsu;
		cpu_data_t   exp_di;
		@(negedge mclk);
		check_bit("rom_ce_n", exp_rom_ce_n, rom_ce_n);
		check_bit("bsram_ce_n", exp_bsram_ce_n, bsram_ce_n);
		check_bit("rom_oe_n", exp_rd_n, rom_oe_n);
		check_bit("bsram_oe_n", exp_rd_n, bsram_oe_n);
		check_bit("bsram_we_n", exp_wr_n, bsram_we_n);
		check_bit("rom_word", 1'b0, rom_word);
		if (have_prev) begin
			check_addr("rom_addr", exp_rom_addr, rom_addr);
			check_ram_addr("bsram_addr", exp_bsram_addr, bsram_addr);
			check_byte("bsram_d", exp_do, bsram_d);
		end
		check_word("msu_track_num", model_track_num, msu_track_num);
		check_byte("msu_volume", model_volume, msu_volume);
		check_bit("msu_audio_playing", model_playing, msu_audio_playing);
		check_bit("msu_audio_repeat", model_repeat, msu_audio_repeat);
		check_bit("msu_track_request", exp_req, msu_track_request);

		r = $urandom;
		if (new_type) begin
			rom_type = r[7:0];
		end
		r = $urandom;
		rom_mask = r[23:0];
		r = $urandom;
		ram_mask = r[19:0];
		r = $urandom;
		ca = r[23:0];
		r = $urandom;
		cpurd_n            = r[0];
		cpuwr_n            = r[1];
		romsel_n           = r[2];
		ramsel_n           = (r[5:3] != 3'd0);
		sysclkf_ce         = r[6];
		msu_track_mounting = r[7];
		msu_track_missing  = r[8];
		msu_audio_stop     = (r[11:9] == 3'd0);
		cpu_do             = r[19:12];
		msu_enable         = msu_focus ? (r[22:20] != 3'd0) : 1'b0;
		// Most MSU cycles land in the register window of a system bank.
		if (msu_focus && (r[24:23] != 2'd0)) begin
			ca[22]   = 1'b0;
			ca[15:0] = {msu_base[15:3], ca[2:0]};
		end
		r = $urandom;
		rom_q   = r[15:0];
		bsram_q = r[23:16];

		#1;
		model_decode(rom_type, exp_act, exp_hirom, exp_ss, exp_turbo, exp_gsu);
		check_active("map_active", exp_act, map_active);
		check_bit("ss_avail", exp_ss, ss_avail);
		check_bit("turbo_allow", exp_turbo, turbo_allow);
		check_bit("gsu_active", exp_gsu, gsu_active);

		if (model_msu_hit(msu_base, msu_enable, ca) && !cpurd_n) begin
			exp_di = model_msu_read(ca, msu_track_mounting, msu_track_missing);
		end else if (!exp_rom_ce_n) begin
			exp_di = exp_rom_addr[0] ? rom_q[15:8] : rom_q[7:0];
		end else if (!exp_bsram_ce_n) begin
			exp_di = bsram_q;
		end else begin
			exp_di = 8'h00;
		end
		check_byte("cpu_di", exp_di, cpu_di);

		model_map(ca, romsel_n, ramsel_n, exp_hirom, rom_mask, ram_mask,
			exp_rom_addr, exp_rom_ce_n, exp_bsram_addr, exp_bsram_ce_n);
		exp_rd_n  = cpurd_n;
		exp_wr_n  = cpuwr_n;
		exp_do    = cpu_do;
		have_prev = 1'b1;
		exp_req   = model_msu_step(msu_base, msu_enable, ca, cpuwr_n, sysclkf_ce, cpu_do,
			msu_audio_stop);
	endtask

	initial begin
		void'($urandom(32'h3a7462a0));
		errors             = 0;
		rst_n              = 1'b0;
		rom_type           = 8'h00;
		rom_mask           = '1;
		ram_mask           = '1;
		ca                 = '0;
		cpurd_n            = 1'b1;
		cpuwr_n            = 1'b1;
		romsel_n           = 1'b1;
		ramsel_n           = 1'b1;
		cpu_do             = '0;
		sysclkf_ce         = 1'b0;
		rom_q              = '0;
		bsram_q            = '0;
		msu_enable         = 1'b0;
		msu_track_mounting = 1'b0;
		msu_track_missing  = 1'b0;
		msu_audio_stop     = 1'b0;
		exp_rom_addr       = '0;
		exp_bsram_addr     = '0;
		exp_rom_ce_n       = 1'b1;
		exp_bsram_ce_n     = 1'b1;
		exp_rd_n           = 1'b1;
		exp_wr_n           = 1'b1;
		exp_do             = '0;
		exp_req            = 1'b0;
		have_prev          = 1'b0;
		model_msu_reset();

		repeat (3) @(posedge mclk);
		@(negedge mclk);
		rst_n = 1'b1;
		#1;
		check_bit("rom_ce_n", 1'b1, rom_ce_n);
		check_bit("rom_oe_n", 1'b1, rom_oe_n);
		check_bit("bsram_ce_n", 1'b1, bsram_ce_n);
		check_bit("bsram_oe_n", 1'b1, bsram_oe_n);
		check_bit("bsram_we_n", 1'b1, bsram_we_n);
		check_bit("msu_track_request", 1'b0, msu_track_request);
		check_bit("msu_audio_playing", 1'b0, msu_audio_playing);
		check_bit("msu_audio_repeat", 1'b0, msu_audio_repeat);

		repeat (n_decode) bus_cycle(1'b1, 1'b0);
		repeat (n_map) bus_cycle(1'b1, 1'b0);
		repeat (n_msu) bus_cycle(1'b0, 1'b1);

		if (errors == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1, "Run ended with mismatches.");
		end
	end

endmodule

// ==== design/snes_cart_bus.sv ====
`timescale 1ns/1ns

module snes_cart_bus #(
	parameter logic [15:0] msu_base = 16'h2000
) (
	input  logic                       mclk,
	input  logic                       rst_n,
	input  snes_cart_pkg::cart_type_u  rom_type,
	input  snes_cart_pkg::rom_addr_t   rom_mask,
	input  snes_cart_pkg::bsram_addr_t ram_mask,
	input  snes_cart_pkg::cpu_addr_t   ca,
	input  logic                       cpurd_n,
	input  logic                       cpuwr_n,
	input  logic                       romsel_n,
	input  logic                       ramsel_n,
	input  snes_cart_pkg::cpu_data_t   cpu_do,
	input  logic                       sysclkf_ce,
	output snes_cart_pkg::cpu_data_t   cpu_di,
	output snes_cart_pkg::rom_addr_t   rom_addr,
	input  snes_cart_pkg::rom_word_t   rom_q,
	output logic                       rom_ce_n,
	output logic                       rom_oe_n,
	output logic                       rom_word,
	output snes_cart_pkg::bsram_addr_t bsram_addr,
	output snes_cart_pkg::cpu_data_t   bsram_d,
	input  snes_cart_pkg::cpu_data_t   bsram_q,
	output logic                       bsram_ce_n,
	output logic                       bsram_oe_n,
	output logic                       bsram_we_n,
	output snes_cart_pkg::map_active_t map_active,
	output logic                       ss_avail,
	output logic                       turbo_allow,
	output logic                       gsu_active,
	input  logic                       msu_enable,
	output logic [15:0]                msu_track_num,
	output logic                       msu_track_request,
	input  logic                       msu_track_mounting,
	input  logic                       msu_track_missing,
	output snes_cart_pkg::cpu_data_t   msu_volume,
	input  logic                       msu_audio_stop,
	output logic                       msu_audio_repeat,
	output logic                       msu_audio_playing
);

	import snes_cart_pkg::*;

	logic      hirom;
	logic      rom_sel;
	logic      bsram_sel;
	logic      msu_sel;
	cpu_data_t msu_do;

	cart_type_decode type_dec0 (
		.rom_type    (rom_type),
		.map_active  (map_active),
		.hirom       (hirom),
		.ss_avail    (ss_avail),
		.turbo_allow (turbo_allow),
		.gsu_active  (gsu_active)
	);

	lohi_rom_map map0 (
		.mclk       (mclk),
		.rst_n      (rst_n),
		.ca         (ca),
		.cpurd_n    (cpurd_n),
		.cpuwr_n    (cpuwr_n),
		.romsel_n   (romsel_n),
		.ramsel_n   (ramsel_n),
		.cpu_do     (cpu_do),
		.hirom      (hirom),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.rom_addr   (rom_addr),
		.rom_ce_n   (rom_ce_n),
		.rom_oe_n   (rom_oe_n),
		.rom_word   (rom_word),
		.bsram_addr (bsram_addr),
		.bsram_d    (bsram_d),
		.bsram_ce_n (bsram_ce_n),
		.bsram_oe_n (bsram_oe_n),
		.bsram_we_n (bsram_we_n),
		.rom_sel    (rom_sel),
		.bsram_sel  (bsram_sel)
	);

	msu_regs #(
		.msu_base (msu_base)
	) msu0 (
		.mclk               (mclk),
		.rst_n              (rst_n),
		.msu_enable         (msu_enable),
		.ca                 (ca),
		.cpurd_n            (cpurd_n),
		.cpuwr_n            (cpuwr_n),
		.sysclkf_ce         (sysclkf_ce),
		.cpu_do             (cpu_do),
		.msu_track_mounting (msu_track_mounting),
		.msu_track_missing  (msu_track_missing),
		.msu_audio_stop     (msu_audio_stop),
		.msu_sel            (msu_sel),
		.msu_do             (msu_do),
		.msu_track_num      (msu_track_num),
		.msu_track_request  (msu_track_request),
		.msu_volume         (msu_volume),
		.msu_audio_repeat   (msu_audio_repeat),
		.msu_audio_playing  (msu_audio_playing)
	);

	// The registered ROM address carries the byte lane of the pending read.
	cart_data_mux mux0 (
		.rom_q     (rom_q),
		.bsram_q   (bsram_q),
		.rom_sel   (rom_sel),
		.bsram_sel (bsram_sel),
		.byte_hi   (rom_addr[0]),
		.msu_sel   (msu_sel),
		.msu_do    (msu_do),
		.cpu_di    (cpu_di)
	);

endmodule

// ==== design/cart_data_mux.sv ====
`timescale 1ns/1ns

module cart_data_mux (
	input  snes_cart_pkg::rom_word_t rom_q,
	input  snes_cart_pkg::cpu_data_t bsram_q,
	input  logic                     rom_sel,
	input  logic                     bsram_sel,
	input  logic                     byte_hi,
	input  logic                     msu_sel,
	input  snes_cart_pkg::cpu_data_t msu_do,
	output snes_cart_pkg::cpu_data_t cpu_di
);

	logic [7:0] rom_byte;
	logic [7:0] cart_byte;

	// Odd addresses take the upper half of the ROM word.
	assign rom_byte = byte_hi ? rom_q[15:8] : rom_q[7:0];

	always_comb begin
		if (rom_sel) begin
			cart_byte = rom_byte;
		end else if (bsram_sel) begin
			cart_byte = bsram_q;
		end else begin
			cart_byte = 8'h00;
		end
	end

	// MSU registers sit in system space and win over cart data.
	assign cpu_di = msu_sel ? msu_do : cart_byte;

endmodule

// ==== design/msu_regs.sv ====
`timescale 1ns/1ns

module msu_regs #(
	parameter logic [15:0] msu_base = 16'h2000
) (
	input  logic                     mclk,
	input  logic                     rst_n,
	input  logic                     msu_enable,
	input  snes_cart_pkg::cpu_addr_t ca,
	input  logic                     cpurd_n,
	input  logic                     cpuwr_n,
	input  logic                     sysclkf_ce,
	input  snes_cart_pkg::cpu_data_t cpu_do,
	input  logic                     msu_track_mounting,
	input  logic                     msu_track_missing,
	input  logic                     msu_audio_stop,
	output logic                     msu_sel,
	output snes_cart_pkg::cpu_data_t msu_do,
	output logic [15:0]              msu_track_num,
	output logic                     msu_track_request,
	output snes_cart_pkg::cpu_data_t msu_volume,
	output logic                     msu_audio_repeat,
	output logic                     msu_audio_playing
);

	import snes_cart_pkg::*;

	logic       win_hit;
	logic [2:0] reg_ofs;
	logic [2:0] id_idx;
	logic       wr_commit;
	cpu_data_t  status;

	// The 8-byte window is mirrored in the system banks 00-3F and 80-BF.
	assign win_hit   = msu_enable && !ca[22] && (ca[15:3] == msu_base[15:3]);
	assign reg_ofs   = ca[2:0];
	assign id_idx    = reg_ofs - 3'd2;
	assign wr_commit = win_hit && !cpuwr_n && sysclkf_ce;

	assign status = {1'b0, msu_track_mounting, msu_audio_repeat, msu_audio_playing,
		msu_track_missing, 3'b000};

	assign msu_sel = win_hit && !cpurd_n;

	always_comb begin
		if (reg_ofs == msu_reg_status) begin
			msu_do = status;
		end else if (reg_ofs == msu_reg_data) begin
			// No data stream here, so the data port reads as zero.
			msu_do = 8'h00;
		end else begin
			msu_do = msu_id_bytes[id_idx];
		end
	end

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			msu_track_num     <= '0;
			msu_volume        <= '0;
			msu_track_request <= 1'b0;
			msu_audio_playing <= 1'b0;
			msu_audio_repeat  <= 1'b0;
		end else begin
			// Writing the high byte starts the track lookup.
			msu_track_request <= wr_commit && (reg_ofs == msu_reg_track_hi);

			if (wr_commit) begin
				case (reg_ofs)
					msu_reg_track_lo: begin
						msu_track_num[7:0] <= cpu_do;
					end
					msu_reg_track_hi: begin
						msu_track_num[15:8] <= cpu_do;
					end
					msu_reg_volume: begin
						msu_volume <= cpu_do;
					end
					default: begin
						msu_volume <= msu_volume;
					end
				endcase
			end

			// A control write from the CPU is newer than a stop from the player.
			if (wr_commit && (reg_ofs == msu_reg_control)) begin
				msu_audio_playing <= cpu_do[0];
				msu_audio_repeat  <= cpu_do[1];
			end else if (msu_audio_stop) begin
				msu_audio_playing <= 1'b0;
			end
		end
	end

endmodule

// ==== design/lohi_rom_map.sv ====
`timescale 1ns/1ns

module lohi_rom_map (
	input  logic                       mclk,
	input  logic                       rst_n,
	input  snes_cart_pkg::cpu_addr_t   ca,
	input  logic                       cpurd_n,
	input  logic                       cpuwr_n,
	input  logic                       romsel_n,
	input  logic                       ramsel_n,
	input  snes_cart_pkg::cpu_data_t   cpu_do,
	input  logic                       hirom,
	input  snes_cart_pkg::rom_addr_t   rom_mask,
	input  snes_cart_pkg::bsram_addr_t ram_mask,
	output snes_cart_pkg::rom_addr_t   rom_addr,
	output logic                       rom_ce_n,
	output logic                       rom_oe_n,
	output logic                       rom_word,
	output snes_cart_pkg::bsram_addr_t bsram_addr,
	output snes_cart_pkg::cpu_data_t   bsram_d,
	output logic                       bsram_ce_n,
	output logic                       bsram_oe_n,
	output logic                       bsram_we_n,
	output logic                       rom_sel,
	output logic                       bsram_sel
);

	import snes_cart_pkg::*;

	logic [7:0]  bank;
	logic        lo_ram_hit;
	logic        hi_ram_hit;
	logic        hi_bank_rom;
	logic        ram_hit;
	logic        rom_hit;
	rom_addr_t   lo_rom_addr;
	rom_addr_t   hi_rom_addr;
	bsram_addr_t lo_ram_addr;
	bsram_addr_t hi_ram_addr;

	assign bank = ca[23:16];

	// LoROM packs 32K pages, HiROM maps the address linearly.
	assign lo_rom_addr = {2'b00, ca[22:16], ca[14:0]} & rom_mask;
	assign hi_rom_addr = {2'b00, ca[21:0]} & rom_mask;
	assign lo_ram_addr = {1'b0, ca[19:16], ca[14:0]} & ram_mask;
	assign hi_ram_addr = {2'b00, ca[20:16], ca[12:0]} & ram_mask;

	// Banks 70-7D, lower half of each bank.
	assign lo_ram_hit = (bank[7:4] == 4'h7) && (bank[3:1] != 3'b111) && !ca[15];

	// Banks 20-3F and A0-BF at 6000-7FFF.
	assign hi_ram_hit = (bank[6:5] == 2'b01) && (ca[15:13] == 3'b011);

	// Banks 40-7D and C0-FF are full ROM banks in HiROM mode.
	assign hi_bank_rom = (bank[7:6] == 2'b11)
		|| ((bank[7:6] == 2'b01) && (bank[5:1] != 5'b11111));

	// WRAM cycles never reach the cartridge. BSRAM takes priority over ROM.
	assign ram_hit = ramsel_n && (hirom ? hi_ram_hit : lo_ram_hit);
	assign rom_hit = ramsel_n && !ram_hit && (!romsel_n || (hirom && hi_bank_rom));

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			rom_ce_n   <= 1'b1;
			rom_oe_n   <= 1'b1;
			bsram_ce_n <= 1'b1;
			bsram_oe_n <= 1'b1;
			bsram_we_n <= 1'b1;
			rom_sel    <= 1'b0;
			bsram_sel  <= 1'b0;
		end else begin
			rom_ce_n   <= ~rom_hit;
			rom_oe_n   <= cpurd_n;
			bsram_ce_n <= ~ram_hit;
			bsram_oe_n <= cpurd_n;
			bsram_we_n <= cpuwr_n;
			rom_sel    <= rom_hit;
			bsram_sel  <= ram_hit;
		end
	end

	always_ff @(posedge mclk) begin
		rom_addr   <= hirom ? hi_rom_addr : lo_rom_addr;
		bsram_addr <= hirom ? hi_ram_addr : lo_ram_addr;
		bsram_d    <= cpu_do;
	end

	// CPU fetches are byte wide; the byte lane is picked from the read word.
	assign rom_word = 1'b0;

endmodule

// ==== design/cart_type_decode.sv ====
`timescale 1ns/1ns

module cart_type_decode (
	input  snes_cart_pkg::cart_type_u  rom_type,
	output snes_cart_pkg::map_active_t map_active,
	output logic                       hirom,
	output logic                       ss_avail,
	output logic                       turbo_allow,
	output logic                       gsu_active
);

	import snes_cart_pkg::*;

	logic [3:0] chip_id;
	logic       plain_cart;
	logic       dspn_cart;

	assign chip_id = rom_type.coproc.chip_id;

	// At most one enhancement chip is flagged; unknown ids select none.
	always_comb begin
		map_active = '0;
		case (chip_id)
			chip_id_cx4: begin
				map_active[chip_cx4] = 1'b1;
			end
			chip_id_sdd1: begin
				map_active[chip_sdd1] = 1'b1;
			end
			chip_id_gsu: begin
				map_active[chip_gsu] = 1'b1;
			end
			chip_id_sa1: begin
				map_active[chip_sa1] = 1'b1;
			end
			chip_id_spc7110: begin
				map_active[chip_spc7110] = 1'b1;
			end
			chip_id_bsx: begin
				map_active[chip_bsx] = 1'b1;
			end
			chip_id_sufami: begin
				map_active[chip_sufami] = 1'b1;
			end
			default: begin
				map_active = '0;
			end
		endcase
	end

	assign hirom = rom_type.coproc.map_mode[map_mode_hirom];

	assign plain_cart = (chip_id == chip_id_none);
	assign dspn_cart  = (rom_type.dspn.tag == dspn_tag);

	// Savestates cover plain carts, SA1 and the DSPn family.
	assign ss_avail = plain_cart | map_active[chip_sa1] | dspn_cart;

	assign turbo_allow = ~(map_active[chip_sa1] | map_active[chip_sdd1]);
	assign gsu_active  = map_active[chip_gsu];

endmodule

// ==== design/snes_cart_pkg.sv ====
package snes_cart_pkg;

	typedef logic [23:0] cpu_addr_t;
	typedef logic [23:0] rom_addr_t;
	typedef logic [19:0] bsram_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [15:0] rom_word_t;
	typedef logic [6:0]  map_active_t;

	// Bit positions in the active chip vector.
	localparam int chip_cx4     = 0;
	localparam int chip_sdd1    = 1;
	localparam int chip_gsu     = 2;
	localparam int chip_sa1     = 3;
	localparam int chip_spc7110 = 4;
	localparam int chip_bsx     = 5;
	localparam int chip_sufami  = 6;

	// Most carts carry a coprocessor id in the upper nibble.
	typedef struct packed {
		logic [3:0] chip_id;
		logic [3:0] map_mode;
	} coproc_view_t;

	// DSPn carts put a tag and a DSP variant in the same bits.
	typedef struct packed {
		logic [1:0] tag;
		logic [1:0] dsp_variant;
		logic [3:0] map_mode;
	} dspn_view_t;

	typedef union packed {
		coproc_view_t coproc;
		dspn_view_t   dspn;
	} cart_type_u;

	localparam logic [1:0] dspn_tag = 2'b10;

	localparam logic [3:0] chip_id_none    = 4'h0;
	localparam logic [3:0] chip_id_bsx     = 4'h3;
	localparam logic [3:0] chip_id_cx4     = 4'h4;
	localparam logic [3:0] chip_id_sdd1    = 4'h5;
	localparam logic [3:0] chip_id_sa1     = 4'h6;
	localparam logic [3:0] chip_id_gsu     = 4'h7;
	localparam logic [3:0] chip_id_spc7110 = 4'hD;
	localparam logic [3:0] chip_id_sufami  = 4'hE;

	localparam int map_mode_hirom = 0;

	// MSU register offsets from the window base.
	localparam logic [2:0] msu_reg_status   = 3'd0;
	localparam logic [2:0] msu_reg_data     = 3'd1;
	localparam logic [2:0] msu_reg_track_lo = 3'd4;
	localparam logic [2:0] msu_reg_track_hi = 3'd5;
	localparam logic [2:0] msu_reg_volume   = 3'd6;
	localparam logic [2:0] msu_reg_control  = 3'd7;

	localparam logic [0:5][7:0] msu_id_bytes = "S-MSU1";

endpackage
